// File: vlog.f
+incdir+.
mem_access_pkg.sv
fetch_unit.sv
addr_xlate.sv
bus_arbiter.sv
mem_access_top.sv
tb_mem_model.sv
tb_mem_access_top.sv

// File: Makefile
# Verilator build and run for the memory-access testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_access_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0 --assert

SOURCES := $(shell grep -v '^+' vlog.f) mem_access_defines.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): vlog.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f vlog.f --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// File: tb_mem_access_top.sv
`timescale 1ns/1ps
`include "mem_access_defines.svh"

module tb_mem_access_top;

    localparam int N_PHASE   = 4;
    localparam int N_DATA    = 60;                      // Data requests per phase
    localparam int WD_CYCLES = 400 * N_PHASE * (N_DATA + 4);

    typedef struct packed {
        logic                     err;
        logic                     store;
        mem_access_pkg::exc_t     exc;
        mem_access_pkg::mem_req_t req;
    } expect_t;

    logic                       clk;
    logic                       reset_i;
    logic                       usermode_i;
    logic                       redirect_i;
    logic [`ADDR_W-1:0]         redirect_pc_i;
    logic                       d_valid_i;
    mem_access_pkg::dreq_t      d_req_i;
    logic [`DATA_W-1:0]         mem_rdata_i;
    logic                       mem_streq_i;
    logic                       inst_valid_o;
    mem_access_pkg::fetch_rsp_t inst_o;
    logic                       i_exc_valid_o;
    mem_access_pkg::exc_t       i_exc_o;
    logic                       d_ready_o;
    logic                       d_done_o;
    logic [`DATA_W-1:0]         d_rdata_o;
    logic                       d_exc_valid_o;
    mem_access_pkg::exc_t       d_exc_o;
    logic                       mem_en_o;
    mem_access_pkg::mem_req_t   mem_req_o;

    expect_t                    dq[$];                  // Accepted data accesses in order
    logic [`ADDR_W-1:0]         exp_pc;
    logic                       um_fetch;
    logic                       f_halted;
    logic                       stall_prev;
    mem_access_pkg::mem_req_t   req_prev;
    int                         n_inst;
    int                         n_ddone;

    mem_access_top u_dut (
        .clk          (clk),           .reset_i      (reset_i),
        .usermode_i   (usermode_i),    .redirect_i   (redirect_i),
        .redirect_pc_i(redirect_pc_i), .d_valid_i    (d_valid_i),
        .d_req_i      (d_req_i),       .mem_rdata_i  (mem_rdata_i),
        .mem_streq_i  (mem_streq_i),   .inst_valid_o (inst_valid_o),
        .inst_o       (inst_o),        .i_exc_valid_o(i_exc_valid_o),
        .i_exc_o      (i_exc_o),       .d_ready_o    (d_ready_o),
        .d_done_o     (d_done_o),      .d_rdata_o    (d_rdata_o),
        .d_exc_valid_o(d_exc_valid_o), .d_exc_o      (d_exc_o),
        .mem_en_o     (mem_en_o),      .mem_req_o    (mem_req_o)
    );

    tb_mem_model u_mem (
        .clk        (clk),      .reset_i    (reset_i),
        .mem_en_i   (mem_en_o), .mem_req_i  (mem_req_o),
        .mem_rdata_o(mem_rdata_i), .mem_streq_o(mem_streq_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ********************
    // Reference model
    // ********************
    function automatic expect_t predict(input logic [`ADDR_W-1:0] va, input logic st,
                                        input mem_access_pkg::size_e sz,
                                        input logic [`DATA_W-1:0] wd, input logic um);
        expect_t    e;
        logic [2:0] seg;
        seg          = va[31:29];
        e.store      = st;
        e.req.size   = sz;
        e.req.cached = (seg != 3'b101);
        e.req.paddr  = (seg == 3'b100 || seg == 3'b101) ? (va & `KSEG_MASK) : va;
        case (sz)
            mem_access_pkg::SIZE_BYTE: begin
                e.req.ben   = 4'b0001 << va[1:0];
                e.req.wdata = {4{wd[7:0]}};
                e.err       = 1'b0;
            end
            mem_access_pkg::SIZE_HALF: begin
                e.req.ben   = va[1] ? 4'b1100 : 4'b0011;
                e.req.wdata = {2{wd[15:0]}};
                e.err       = va[0];
            end
            default: begin
                e.req.ben   = 4'b1111;
                e.req.wdata = wd;
                e.err       = (va[1:0] != 2'b00);
            end
        endcase
        e.err          = e.err || (um && va[31]);
        e.exc.code     = st ? mem_access_pkg::ADES : mem_access_pkg::ADEL;
        e.exc.badvaddr = va;
        return e;
    endfunction

    // ********************
    // Checks
    // ********************
    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_fetch(input mem_access_pkg::fetch_rsp_t act,
                               input mem_access_pkg::fetch_rsp_t exp);
        if (act !== exp) begin
            report_fail($sformatf("FAILED inst_o: got 0x%h, expected 0x%h", act, exp));
        end
    endtask

    task automatic check_mem_req(input string name, input mem_access_pkg::mem_req_t act,
                                 input mem_access_pkg::mem_req_t exp);
        if (act !== exp) begin
            report_fail($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, act, exp));
        end
    endtask

    task automatic check_exc(input string name, input mem_access_pkg::exc_t act,
                             input mem_access_pkg::exc_t exp);
        if (act !== exp) begin
            report_fail($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, act, exp));
        end
    endtask

    task automatic check_rdata(input logic [`DATA_W-1:0] act, input logic [`DATA_W-1:0] exp);
        if (act !== exp) begin
            report_fail($sformatf("FAILED d_rdata_o: got 0x%h, expected 0x%h", act, exp));
        end
    endtask

    task automatic check_level(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            report_fail($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, act, exp));
        end
    endtask

    // Outputs sampled mid-cycle where they are settled
    always @(negedge clk) begin
        expect_t e;
        logic    exp_ready;
        if (!reset_i) begin
            if (stall_prev) begin
                if (!mem_en_o) begin
                    report_fail("memory port dropped its request during a stall");
                end
                check_mem_req("mem_req_o", mem_req_o, req_prev);
            end
            stall_prev = mem_en_o && mem_streq_i;
            req_prev   = mem_req_o;

            e = predict(exp_pc, 1'b0, mem_access_pkg::SIZE_WORD, '0, um_fetch);
            if ((inst_valid_o || i_exc_valid_o) && f_halted) begin
                report_fail("fetch stream kept running after a fetch exception");
            end
            if (inst_valid_o) begin
                if (e.err) begin
                    report_fail("instruction delivered for a faulting pc");
                end
                check_level("mem_en_o", mem_en_o, 1'b1);
                check_fetch(inst_o, {exp_pc, u_mem.read_word(e.req.paddr)});
                check_mem_req("mem_req_o", mem_req_o, e.req);
                exp_pc = exp_pc + 32'd4;
                n_inst++;
            end
            if (i_exc_valid_o) begin
                if (!e.err) begin
                    report_fail("fetch exception raised for a legal pc");
                end
                check_exc("i_exc_o", i_exc_o, e.exc);
                f_halted = 1'b1;
            end
            if (redirect_i) begin                       // New stream from the next edge
                exp_pc   = redirect_pc_i;
                um_fetch = usermode_i;
                f_halted = 1'b0;
            end

            // Slot frees on a response
            exp_ready = (dq.size() == 0) || d_done_o || d_exc_valid_o;
            check_level("d_ready_o", d_ready_o, exp_ready);

            if (d_done_o || d_exc_valid_o) begin
                if (dq.size() == 0) begin
                    report_fail("data response with no request outstanding");
                end
                e = dq.pop_front();
                if (d_done_o) begin
                    if (e.err) begin
                        report_fail("faulting data access reached the memory port");
                    end
                    check_level("mem_en_o", mem_en_o, 1'b1);
                    check_mem_req("mem_req_o", mem_req_o, e.req);
                    if (e.store) begin
                        u_mem.write_word(e.req.paddr, e.req.ben, e.req.wdata);
                    end else begin
                        check_rdata(d_rdata_o, u_mem.read_word(e.req.paddr));
                    end
                    n_ddone++;
                end else begin
                    if (!e.err) begin
                        report_fail("data exception raised for a legal access");
                    end
                    check_exc("d_exc_o", d_exc_o, e.exc);
                end
            end
            if (d_valid_i && d_ready_o) begin
                dq.push_back(predict(d_req_i.vaddr, d_req_i.store, d_req_i.size,
                                     d_req_i.wdata, usermode_i));
            end
        end
    end

    // ********************
    // Stimulus
    // ********************
    function automatic logic [`ADDR_W-1:0] random_pc();
        logic [31:0] r;
        logic [2:0]  seg;
        r = $urandom;
        case (r[1:0])
            2'd0:    seg = 3'b000;
            2'd1:    seg = 3'b100;
            default: seg = 3'b101;
        endcase
        return {seg, 17'd0, r[12:3], (r[15:13] == 3'd0) ? r[17:16] : 2'b00};
    endfunction

    function automatic mem_access_pkg::dreq_t random_dreq();
        mem_access_pkg::dreq_t d;
        logic [31:0]           r;
        logic [2:0]            seg;
        logic [1:0]            low;
        r = $urandom;
        case (r[1:0])
            2'd0:    seg = 3'b000;
            2'd1:    seg = 3'b100;
            2'd2:    seg = 3'b101;
            default: seg = 3'b110;
        endcase
        d.size = (r[3:2] == 2'd3) ? mem_access_pkg::SIZE_WORD : mem_access_pkg::size_e'(r[3:2]);
        low    = r[5:4];
        if (r[8:6] != 3'd0) begin                       // Mostly aligned
            if (d.size == mem_access_pkg::SIZE_WORD) begin
                low = 2'b00;
            end else if (d.size == mem_access_pkg::SIZE_HALF) begin
                low[0] = 1'b0;
            end
        end
        d.vaddr = {seg, 17'd0, r[18:9], low};           // Small window so segments alias
        d.store = r[19];
        d.wdata = $urandom;
        return d;
    endfunction

    task automatic issue_data(input mem_access_pkg::dreq_t r);
        d_valid_i = 1'b1;
        d_req_i   = r;
        @(negedge clk);
        while (!d_ready_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        d_valid_i = 1'b0;
    endtask

    task automatic redirect_to(input logic um);
        usermode_i    = um;
        redirect_i    = 1'b1;
        redirect_pc_i = random_pc();
        @(posedge clk);
        #2;
        redirect_i    = 1'b0;
    endtask

    initial begin
        void'($urandom(90241));
        reset_i       = 1'b1;
        usermode_i    = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        d_valid_i     = 1'b0;
        d_req_i       = '0;
        exp_pc        = `RESET_PC;
        um_fetch      = 1'b0;
        f_halted      = 1'b0;
        stall_prev    = 1'b0;
        req_prev      = '0;
        n_inst        = 0;
        n_ddone       = 0;
        repeat (10) @(posedge clk);
        #2;
        reset_i = 1'b0;

        // Phase 0 runs the boot stream and odd phases run in user mode
        for (int p = 0; p < N_PHASE; p++) begin
            if (p != 0) begin
                redirect_to(p[0]);
            end
            for (int n = 0; n < N_DATA; n++) begin
                issue_data(random_dreq());
                repeat ($urandom_range(3)) begin
                    @(posedge clk);
                    #2;
                end
                if (n % 20 == 10) begin
                    redirect_to(usermode_i);
                end
            end
        end
        while (dq.size() != 0) begin
            @(negedge clk);
        end

        if (n_inst == 0 || n_ddone == 0) begin
            report_fail("no instruction or no data access completed");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        report_fail("watchdog expired before all requests completed");
    end

endmodule

// File: tb_mem_model.sv
`timescale 1ns/1ps
`include "mem_access_defines.svh"

module tb_mem_model (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     mem_en_i,
    input  mem_access_pkg::mem_req_t mem_req_i,
    output logic [`DATA_W-1:0]       mem_rdata_o,
    output logic                     mem_streq_o
);

    // Word storage, keyed by physical word address
    logic [`DATA_W-1:0] words [logic [`ADDR_W-3:0]];

    function automatic logic [`DATA_W-1:0] read_word(input logic [`ADDR_W-1:0] paddr);
        if (words.exists(paddr[`ADDR_W-1:2])) begin
            return words[paddr[`ADDR_W-1:2]];
        end
        return {paddr[15:2], paddr[31:16], 2'b01} ^ 32'h6A09_E667;     // Untouched words
    endfunction

    // Byte lanes merged under the enables
    function automatic void write_word(input logic [`ADDR_W-1:0] paddr,
                                       input logic [`BEN_W-1:0]  ben,
                                       input logic [`DATA_W-1:0] wdata);
        logic [`DATA_W-1:0] w;
        w = read_word(paddr);
        for (int i = 0; i < `BEN_W; i++) begin
            if (ben[i]) begin
                w[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        words[paddr[`ADDR_W-1:2]] = w;
    endfunction

    // ********************
    // Stall generator
    // ********************
    initial begin
        mem_streq_o = 1'b0;
        mem_rdata_o = '0;
        forever begin
            @(posedge clk);
            #2;
            mem_streq_o = !reset_i && mem_en_i && ($urandom_range(3) == 0);
            mem_rdata_o = read_word(mem_req_i.paddr);
        end
    end

endmodule

// File: mem_access_top.sv
`timescale 1ns/1ps
`include "mem_access_defines.svh"

module mem_access_top (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        usermode_i,
    input  logic                        redirect_i,
    input  logic [`ADDR_W-1:0]          redirect_pc_i,
    input  logic                        d_valid_i,
    input  mem_access_pkg::dreq_t       d_req_i,
    input  logic [`DATA_W-1:0]          mem_rdata_i,
    input  logic                        mem_streq_i,
    output logic                        inst_valid_o,
    output mem_access_pkg::fetch_rsp_t  inst_o,
    output logic                        i_exc_valid_o,
    output mem_access_pkg::exc_t        i_exc_o,
    output logic                        d_ready_o,
    output logic                        d_done_o,
    output logic [`DATA_W-1:0]          d_rdata_o,
    output logic                        d_exc_valid_o,
    output mem_access_pkg::exc_t        d_exc_o,
    output logic                        mem_en_o,
    output mem_access_pkg::mem_req_t    mem_req_o
);

    logic                        f_valid;
    logic [`ADDR_W-1:0]          f_vaddr;
    mem_access_pkg::fetch_meta_t f_meta;
    logic                        ix_ready, ix_done, ix_req, ix_exc_valid;
    mem_access_pkg::fetch_meta_t ix_meta;
    logic [`DATA_W-1:0]          ix_rdata;
    mem_access_pkg::exc_t        ix_exc;
    mem_access_pkg::mem_req_t    ix_bus, dx_bus;
    logic                        dx_req, arb_i_done, arb_d_done;
    logic [`DATA_W-1:0]          arb_rdata;

    fetch_unit u_fetch (
        .clk          (clk),           .reset_i       (reset_i),
        .redirect_i   (redirect_i),    .redirect_pc_i (redirect_pc_i),
        .x_ready_i    (ix_ready),      .x_done_i      (ix_done),
        .x_meta_i     (ix_meta),       .x_rdata_i     (ix_rdata),
        .x_exc_valid_i(ix_exc_valid),  .x_exc_meta_i  (ix_meta),
        .x_exc_i      (ix_exc),        .x_valid_o     (f_valid),
        .x_vaddr_o    (f_vaddr),       .x_meta_o      (f_meta),
        .inst_valid_o (inst_valid_o),  .inst_o        (inst_o),
        .i_exc_valid_o(i_exc_valid_o), .i_exc_o       (i_exc_o)
    );

    // Fetch side, always word loads
    addr_xlate #(.payload_t(mem_access_pkg::fetch_meta_t)) u_ixlate (
        .clk         (clk),          .reset_i   (reset_i),
        .usermode_i  (usermode_i),   .valid_i   (f_valid),
        .vaddr_i     (f_vaddr),      .store_i   (1'b0),
        .size_i      (mem_access_pkg::SIZE_WORD),
        .wdata_i     ('0),           .payload_i (f_meta),
        .grant_done_i(arb_i_done),   .rdata_i   (arb_rdata),
        .ready_o     (ix_ready),     .req_o     (ix_req),
        .req_o_bus   (ix_bus),       .done_o    (ix_done),
        .payload_o   (ix_meta),      .rdata_o   (ix_rdata),
        .exc_valid_o (ix_exc_valid), .exc_o     (ix_exc)
    );

    addr_xlate #(.payload_t(mem_access_pkg::data_meta_t)) u_dxlate (
        .clk         (clk),           .reset_i   (reset_i),
        .usermode_i  (usermode_i),    .valid_i   (d_valid_i),
        .vaddr_i     (d_req_i.vaddr), .store_i   (d_req_i.store),
        .size_i      (d_req_i.size),  .wdata_i   (d_req_i.wdata),
        .payload_i   (mem_access_pkg::data_meta_t'(d_req_i.vaddr)),
        .grant_done_i(arb_d_done),    .rdata_i   (arb_rdata),
        .ready_o     (d_ready_o),     .req_o     (dx_req),
        .req_o_bus   (dx_bus),        .done_o    (d_done_o),
        .payload_o   (),              .rdata_o   (d_rdata_o),
        .exc_valid_o (d_exc_valid_o), .exc_o     (d_exc_o)
    );

    bus_arbiter u_arb (
        .clk        (clk),         .reset_i    (reset_i),
        .i_req_i    (ix_req),      .i_bus_i    (ix_bus),
        .d_req_i    (dx_req),      .d_bus_i    (dx_bus),
        .mem_rdata_i(mem_rdata_i), .mem_streq_i(mem_streq_i),
        .mem_en_o   (mem_en_o),    .mem_req_o  (mem_req_o),
        .i_done_o   (arb_i_done),  .d_done_o   (arb_d_done),
        .rdata_o    (arb_rdata)
    );

endmodule

// File: bus_arbiter.sv
`timescale 1ns/1ps
`include "mem_access_defines.svh"

module bus_arbiter (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     i_req_i,
    input  mem_access_pkg::mem_req_t i_bus_i,
    input  logic                     d_req_i,
    input  mem_access_pkg::mem_req_t d_bus_i,
    input  logic [`DATA_W-1:0]       mem_rdata_i,
    input  logic                     mem_streq_i,
    output logic                     mem_en_o,
    output mem_access_pkg::mem_req_t mem_req_o,
    output logic                     i_done_o,
    output logic                     d_done_o,
    output logic [`DATA_W-1:0]       rdata_o
);

    logic lock_q;
    logic own_d_q;          // High when data stream owns the port
    logic done;

    // ********************
    // Grant
    // ********************

    // Grant taken at the edge, port driven from the next cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            lock_q  <= 1'b0;
            own_d_q <= 1'b0;
        end else if (!lock_q) begin
            if (d_req_i || i_req_i) begin
                lock_q  <= 1'b1;
                own_d_q <= d_req_i;     // Data first
            end
        end else if (done) begin
            lock_q <= 1'b0;             // Rearbitrate next cycle
        end
    end

    // ********************
    // Port and completions
    // ********************

    assign mem_en_o = lock_q;

    always_comb begin
        if (own_d_q) begin
            mem_req_o = d_bus_i;
        end else begin
            mem_req_o = i_bus_i;
        end
    end

    assign done     = lock_q && !mem_streq_i;
    assign i_done_o = done && !own_d_q;
    assign d_done_o = done && own_d_q;
    assign rdata_o  = mem_rdata_i;

    // Stalled access must not move
    a_hold_on_stall: assert property (@(posedge clk) disable iff (reset_i)
        mem_en_o && mem_streq_i |=> $stable(mem_req_o));

    // Owner keeps its request up for the whole grant
    a_owner_req: assert property (@(posedge clk) disable iff (reset_i)
        mem_en_o |-> (own_d_q ? d_req_i : i_req_i));

endmodule

// File: addr_xlate.sv
`timescale 1ns/1ps
`include "mem_access_defines.svh"

module addr_xlate #(
    parameter type payload_t = logic
) (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      usermode_i,
    input  logic                      valid_i,
    input  logic [`ADDR_W-1:0]        vaddr_i,
    input  logic                      store_i,
    input  mem_access_pkg::size_e     size_i,
    input  logic [`DATA_W-1:0]        wdata_i,
    input  payload_t                  payload_i,
    input  logic                      grant_done_i,
    input  logic [`DATA_W-1:0]        rdata_i,
    output logic                      ready_o,
    output logic                      req_o,
    output mem_access_pkg::mem_req_t  req_o_bus,
    output logic                      done_o,
    output payload_t                  payload_o,
    output logic [`DATA_W-1:0]        rdata_o,
    output logic                      exc_valid_o,
    output mem_access_pkg::exc_t      exc_o
);

    logic                     full_q;
    logic                     err_q;
    mem_access_pkg::mem_req_t bus_q;
    mem_access_pkg::exc_t     exc_q;
    payload_t                 payload_q;

    mem_access_pkg::mem_req_t bus_d;
    mem_access_pkg::exc_t     exc_d;
    logic [2:0]               seg;
    logic                     misalign;
    logic                     err_d;
    logic                     accept;

    assign seg = vaddr_i[`ADDR_W-1:`ADDR_W-3];

    // ********************
    // Fixed mapping
    // ********************
    always_comb begin
        // kseg0 = 100, kseg1 = 101
        if (seg[2:1] == 2'b10) begin
            bus_d.paddr = vaddr_i & `KSEG_MASK;
        end else begin
            bus_d.paddr = vaddr_i;
        end
        bus_d.cached = (seg != 3'b101);     // kseg1 is uncached
        bus_d.size   = size_i;

        case (size_i)
            mem_access_pkg::SIZE_BYTE: begin
                bus_d.ben   = `BEN_W'(1) << vaddr_i[1:0];
                bus_d.wdata = {4{wdata_i[7:0]}};
                misalign    = 1'b0;
            end
            mem_access_pkg::SIZE_HALF: begin
                bus_d.ben   = vaddr_i[1] ? 4'b1100 : 4'b0011;
                bus_d.wdata = {2{wdata_i[15:0]}};
                misalign    = vaddr_i[0];
            end
            default: begin
                bus_d.ben   = 4'b1111;
                bus_d.wdata = wdata_i;
                misalign    = |vaddr_i[1:0];
            end
        endcase

        // Kernel space off limits in user mode
        err_d = misalign || (usermode_i && vaddr_i[`ADDR_W-1]);

        exc_d.badvaddr = vaddr_i;
        if (store_i) begin
            exc_d.code = mem_access_pkg::ADES;
        end else begin
            exc_d.code = mem_access_pkg::ADEL;
        end
    end

    // ********************
    // Request slot
    // ********************
    assign ready_o = !full_q || grant_done_i || exc_valid_o;   // Frees same cycle
    assign accept  = valid_i && ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (grant_done_i || exc_valid_o) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bus_q     <= bus_d;
            err_q     <= err_d;
            exc_q     <= exc_d;
            payload_q <= payload_i;
        end
    end

    assign req_o       = full_q && !err_q;
    assign exc_valid_o = full_q && err_q;    // One cycle, slot empties behind it
    assign req_o_bus   = bus_q;
    assign exc_o       = exc_q;
    assign payload_o   = payload_q;
    assign done_o      = grant_done_i;
    assign rdata_o     = rdata_i;

    // Faulting access never sees the port or a completion
    a_no_exc_on_bus: assert property (@(posedge clk) disable iff (reset_i)
        !(exc_valid_o && (req_o || grant_done_i)));

    a_slot_stable: assert property (@(posedge clk) disable iff (reset_i)
        req_o && !grant_done_i |=> req_o && $stable(req_o_bus) && $stable(payload_o));

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps
`include "mem_access_defines.svh"

module fetch_unit (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        redirect_i,
    input  logic [`ADDR_W-1:0]          redirect_pc_i,
    input  logic                        x_ready_i,
    input  logic                        x_done_i,
    input  mem_access_pkg::fetch_meta_t x_meta_i,
    input  logic [`DATA_W-1:0]          x_rdata_i,
    input  logic                        x_exc_valid_i,
    input  mem_access_pkg::fetch_meta_t x_exc_meta_i,
    input  mem_access_pkg::exc_t        x_exc_i,
    output logic                        x_valid_o,
    output logic [`ADDR_W-1:0]          x_vaddr_o,
    output mem_access_pkg::fetch_meta_t x_meta_o,
    output logic                        inst_valid_o,
    output mem_access_pkg::fetch_rsp_t  inst_o,
    output logic                        i_exc_valid_o,
    output mem_access_pkg::exc_t        i_exc_o
);

    logic [`ADDR_W-1:0] pc_q;
    logic               epoch_q;
    logic               halt_q;
    logic               exc_hit;
    logic               accept;

    // ********************
    // Request side
    // ********************

    // Exception of the live stream, stale ones are dropped
    assign exc_hit = x_exc_valid_i && (x_exc_meta_i.epoch == epoch_q) && !halt_q;

    // Hold off in the exception cycle too, the slot frees right then
    assign x_valid_o = !halt_q && !exc_hit;
    assign accept    = x_valid_o && x_ready_i;

    assign x_vaddr_o      = pc_q;
    assign x_meta_o.pc    = pc_q;
    assign x_meta_o.epoch = epoch_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q    <= `RESET_PC;
            epoch_q <= 1'b0;
            halt_q  <= 1'b0;
        end else if (redirect_i) begin
            pc_q    <= redirect_pc_i;
            epoch_q <= ~epoch_q;        // Marks everything in flight stale
            halt_q  <= 1'b0;
        end else begin
            if (accept) begin
                pc_q <= pc_q + `ADDR_W'd4;
            end
            if (exc_hit) begin
                halt_q <= 1'b1;
            end
        end
    end

    // ********************
    // Response side
    // ********************

    assign inst_valid_o = x_done_i && (x_meta_i.epoch == epoch_q) && !halt_q;
    assign inst_o.pc    = x_meta_i.pc;
    assign inst_o.inst  = x_rdata_i;

    assign i_exc_valid_o = exc_hit;
    assign i_exc_o       = x_exc_i;

    // Fetching stays off from the exception until a redirect
    a_halt_holds: assert property (@(posedge clk) disable iff (reset_i)
        (i_exc_valid_o || halt_q) && !redirect_i |=> !x_valid_o);

endmodule

// File: mem_access_pkg.sv
`include "mem_access_defines.svh"

package mem_access_pkg;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    // MIPS ExcCode values
    typedef enum logic [4:0] {
        ADEL = 5'h04,                   // Fetch or load
        ADES = 5'h05                    // Store
    } exc_code_e;

    typedef struct packed {
        logic [`ADDR_W-1:0] paddr;
        logic [`BEN_W-1:0]  ben;
        logic [`DATA_W-1:0] wdata;
        size_e              size;
        logic               cached;
    } mem_req_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] pc;
        logic               epoch;
    } fetch_meta_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] vaddr;
    } data_meta_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] vaddr;
        logic               store;
        size_e              size;
        logic [`DATA_W-1:0] wdata;
    } dreq_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] pc;
        logic [`DATA_W-1:0] inst;
    } fetch_rsp_t;

    typedef struct packed {
        exc_code_e          code;
        logic [`ADDR_W-1:0] badvaddr;
    } exc_t;

endpackage

// File: mem_access_defines.svh
`ifndef MEM_ACCESS_DEFINES_SVH
`define MEM_ACCESS_DEFINES_SVH

// ********************
// Bus widths
// ********************

`define ADDR_W      32              // Virtual and physical
`define DATA_W      32
`define BEN_W       4               // One enable per byte lane

// ********************
// Address map
// ********************

// Boot vector, lies in kseg1
`define RESET_PC    32'hBFC0_0000

// kseg0 and kseg1 both fold onto the low 512 MB
`define KSEG_MASK   32'h1FFF_FFFF

`endif
